// ==== list.f ====
+incdir+include
src/rv_m_isa_pkg.sv
src/rv_m_unit_pkg.sv
src/rv_m_mul.sv
src/rv_m_div.sv
src/rv_m_writeback_arb.sv
src/rv_m_unit.sv
verification/rv_m_unit_assert.sv
verification/rv_m_unit_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rv_m_unit_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert --timing -Wno-fatal
SIM_ARGS  ?= +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Some tests failed" $(LOG); then \
	  echo "Simulation failed, see $(LOG)"; exit 1; \
	elif ! grep -q "All tests passed" $(LOG); then \
	  echo "Simulation did not finish, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== verification/rv_m_unit_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_m_config.svh"

module rv_m_unit_tb;

  localparam int XLEN = `RV_M_XLEN;
  localparam int NUM_TAGS = 2 ** `RV_M_TAG_W;
  localparam int TIMEOUT = 300;

  logic                 clk = 1'b0;
  logic                 arst_n;
  logic                 start;
  rv_m_isa_pkg::m_op_t  op;
  rv_m_unit_pkg::word_t rs1;
  rv_m_unit_pkg::word_t rs2;
  rv_m_unit_pkg::tag_t  tag;
  logic                 div_busy;
  logic                 result_valid;
  rv_m_unit_pkg::word_t result;
  rv_m_unit_pkg::tag_t  result_tag;

  // Scoreboard by tag with the last tag reserved for divisions
  rv_m_unit_pkg::word_t exp_val [NUM_TAGS];
  bit                   outstanding [NUM_TAGS];
  bit                   is_mul [NUM_TAGS];
  int                   issue_cyc [NUM_TAGS];
  int                   ret_cyc [NUM_TAGS];
  int                   pending = 0;
  int                   mul_ctr = 0;
  int                   cyc = 0;
  int                   val_errs = 0;
  int                   proto_errs = 0;
  int                   timeouts = 0;
  bit                   busy_armed = 1'b0;
  int                   busy_from = 0;

  rv_m_unit DUT (.*);

  always #2 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  // Expected result from the ISA rules in double-width arithmetic
  function automatic rv_m_unit_pkg::word_t model_result(input rv_m_isa_pkg::m_op_t f,
      input rv_m_unit_pkg::word_t a, input rv_m_unit_pkg::word_t b);
    rv_m_unit_pkg::dword_t sa;
    rv_m_unit_pkg::dword_t sb;
    rv_m_unit_pkg::dword_t za;
    rv_m_unit_pkg::dword_t zb;
    rv_m_unit_pkg::dword_t p;
    sa = {{XLEN{a[XLEN-1]}}, a};
    sb = {{XLEN{b[XLEN-1]}}, b};
    za = {{XLEN{1'b0}}, a};
    zb = {{XLEN{1'b0}}, b};
    // Signed overflow needs no special case at double width
    case (f)
      rv_m_isa_pkg::OP_MUL:    p = za * zb;
      rv_m_isa_pkg::OP_MULH:   p = (sa * sb) >> XLEN;
      rv_m_isa_pkg::OP_MULHSU: p = (sa * zb) >> XLEN;
      rv_m_isa_pkg::OP_MULHU:  p = (za * zb) >> XLEN;
      rv_m_isa_pkg::OP_DIV:    p = $signed(sa) / $signed(sb);
      rv_m_isa_pkg::OP_DIVU:   p = za / zb;
      rv_m_isa_pkg::OP_REM:    p = $signed(sa) % $signed(sb);
      default:                 p = za % zb;
    endcase
    if (f[2] && b == '0) begin
      p = f[1] ? za : '1;
    end
    return p[XLEN-1:0];
  endfunction

  task automatic issue_op(input rv_m_isa_pkg::m_op_t f, input rv_m_unit_pkg::word_t a,
      input rv_m_unit_pkg::word_t b);
    rv_m_unit_pkg::tag_t t;
    t = f[2] ? rv_m_unit_pkg::tag_t'(NUM_TAGS - 1) : rv_m_unit_pkg::tag_t'(mul_ctr);
    @(negedge clk);
    if (outstanding[t]) begin
      $display("Tag %0d issued at %0t while still outstanding", t, $time);
      proto_errs++;
    end
    start = 1'b1;
    op = f;
    rs1 = a;
    rs2 = b;
    tag = t;
    exp_val[t] = model_result(f, a, b);
    outstanding[t] = 1'b1;
    is_mul[t] = !f[2];
    issue_cyc[t] = cyc;
    pending++;
    if (f[2]) begin
      busy_armed = 1'b1;
      busy_from = cyc + 1;
    end else begin
      mul_ctr = (mul_ctr + 1) % (NUM_TAGS - 1);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      start = 1'b0;
    end
  endtask

  task automatic wait_drained();
    int n;
    n = 0;
    while (pending != 0 && n < TIMEOUT) begin
      @(posedge clk);
      n++;
    end
    if (pending != 0) begin
      $display("Timeout at %0t with %0d results still outstanding", $time, pending);
      timeouts++;
    end
  endtask

  always @(negedge clk) begin
    // Busy level for the division in flight
    if (busy_armed && cyc >= busy_from && !(result_valid && result_tag == NUM_TAGS - 1)) begin
      assert (div_busy) else begin
        $display("[FAIL] %0t div_busy expected 1 actual %b", $time, div_busy);
        val_errs++;
      end
    end
    // No division in flight, so the divider must be idle
    if (arst_n && !busy_armed) begin
      assert (!div_busy) else begin
        $display("[FAIL] %0t div_busy expected 0 actual %b", $time, div_busy);
        val_errs++;
      end
    end
    if (arst_n && result_valid) begin
      if (!outstanding[result_tag]) begin
        $display("Result at %0t for tag %0d with nothing outstanding", $time, result_tag);
        proto_errs++;
      end else begin
        assert (result == exp_val[result_tag]) else begin
          $display("[FAIL] %0t result expected %h actual %h", $time,
                   exp_val[result_tag], result);
          val_errs++;
        end
        if (is_mul[result_tag]) begin
          assert (cyc - issue_cyc[result_tag] == 3) else begin
            $display("[FAIL] %0t result_valid latency expected 3 actual %0d", $time,
                     cyc - issue_cyc[result_tag]);
            val_errs++;
          end
        end else begin
          busy_armed = 1'b0;
        end
        ret_cyc[result_tag] = cyc;
        outstanding[result_tag] = 1'b0;
        pending--;
      end
    end
  end

  initial begin
    int seed;
    int last_mul;
    rv_m_unit_pkg::word_t corners [5];
    seed = $urandom(11803);
    arst_n = 1'b0;
    start = 1'b0;
    op = '0;
    rs1 = '0;
    rs2 = '0;
    tag = '0;
    corners[0] = {1'b1, {(XLEN-1){1'b0}}};
    corners[1] = '1;
    corners[2] = '0;
    corners[3] = {1'b0, {(XLEN-1){1'b1}}};
    corners[4] = rv_m_unit_pkg::word_t'(3);
    repeat (3) begin
      @(negedge clk);
      assert (!result_valid && !div_busy) else begin
        $display("[FAIL] %0t result_valid/div_busy expected 0/0 actual %b/%b", $time,
                 result_valid, div_busy);
        val_errs++;
      end
    end
    arst_n = 1'b1;
    // Nothing may come out without a start
    idle_cycles(6);

    // Corner pairs with the multiplies as one back-to-back stream
    for (int f = 0; f < 8; f++) begin
      for (int i = 0; i < 5; i++) begin
        for (int j = 0; j < 5; j++) begin
          issue_op(rv_m_isa_pkg::m_op_t'(f), corners[i], corners[j]);
          if (f >= 4) begin
            idle_cycles(1);
            wait_drained();
          end
        end
      end
      idle_cycles(1);
      wait_drained();
    end

    repeat (60) begin
      issue_op(rv_m_isa_pkg::m_op_t'($urandom_range(3, 0)), $urandom, $urandom);
    end
    idle_cycles(1);
    wait_drained();
    repeat (30) begin
      issue_op(rv_m_isa_pkg::m_op_t'($urandom_range(7, 4)), $urandom,
               $urandom >> $urandom_range(31, 0));
      idle_cycles(1);
      wait_drained();
    end

    // Multiply bursts around a running division with the last one over its completion
    for (int k = 0; k < 4; k++) begin
      issue_op(rv_m_isa_pkg::OP_DIV, $urandom, $urandom >> k);
      while (cyc < issue_cyc[NUM_TAGS-1] + XLEN - 10) begin
        repeat (4) issue_op(rv_m_isa_pkg::m_op_t'($urandom_range(3, 0)), $urandom, $urandom);
        idle_cycles(3);
      end
      repeat (12 + k) issue_op(rv_m_isa_pkg::OP_MULHSU, $urandom, $urandom);
      last_mul = (mul_ctr + NUM_TAGS - 2) % (NUM_TAGS - 1);
      idle_cycles(1);
      wait_drained();
      assert (ret_cyc[NUM_TAGS-1] > ret_cyc[last_mul]) else begin
        $display("Division result at %0t came back before the multiply burst ended", $time);
        proto_errs++;
      end
    end

    idle_cycles(4);
    $display("Errors: %0d value, %0d protocol, %0d timeout, %0d assertion", val_errs,
             proto_errs, timeouts, DUT.u_assert.fail_cnt);
    if (val_errs + proto_errs + timeouts + DUT.u_assert.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== verification/rv_m_unit_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_m_unit_assert (
  input logic clk,
  input logic arst_n,
  input logic result_valid,
  input logic div_start,
  input logic div_busy,
  input logic div_done,
  input logic div_ack,
  input logic mul_valid
);

  int fail_cnt = 0;

  valid_known: assert property (@(posedge clk) disable iff (!arst_n)
    !$isunknown(result_valid))
    else begin
      fail_cnt++;
      $error("result_valid is unknown");
    end

  // One division at a time
  no_start_when_busy: assert property (@(posedge clk) disable iff (!arst_n)
    div_start |-> !div_busy)
    else begin
      fail_cnt++;
      $error("division started while the divider was busy");
    end

  done_held: assert property (@(posedge clk) disable iff (!arst_n)
    div_done && !div_ack |=> div_done)
    else begin
      fail_cnt++;
      $error("div_done dropped without div_ack");
    end

  // Multiplier owns the port whenever it has a result
  ack_not_with_mul: assert property (@(posedge clk) disable iff (!arst_n)
    div_ack |-> !mul_valid)
    else begin
      fail_cnt++;
      $error("div_ack raised in a cycle with mul_valid");
    end

endmodule

bind rv_m_unit rv_m_unit_assert u_assert (
  .clk          (clk),
  .arst_n       (arst_n),
  .result_valid (result_valid),
  .div_start    (div_start),
  .div_busy     (div_busy),
  .div_done     (div_done),
  .div_ack      (div_ack),
  .mul_valid    (mul_valid)
);

`default_nettype wire

// ==== src/rv_m_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_m_unit (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 start,
  input  rv_m_isa_pkg::m_op_t  op,
  input  rv_m_unit_pkg::word_t rs1,
  input  rv_m_unit_pkg::word_t rs2,
  input  rv_m_unit_pkg::tag_t  tag,
  output logic                 div_busy,
  output logic                 result_valid,
  output rv_m_unit_pkg::word_t result,
  output rv_m_unit_pkg::tag_t  result_tag
);

  logic                 mul_start;
  logic                 div_start;
  logic                 mul_valid;
  rv_m_unit_pkg::word_t mul_result;
  rv_m_unit_pkg::tag_t  mul_tag;
  logic                 div_done;
  logic                 div_ack;
  rv_m_unit_pkg::word_t div_result;
  rv_m_unit_pkg::tag_t  div_tag;

  // funct3 bit 2 selects the division class
  assign mul_start = start && !op[2];
  assign div_start = start && op[2];

  rv_m_mul u_mul (
    .clk        (clk),
    .arst_n     (arst_n),
    .mul_start  (mul_start),
    .op         (op),
    .rs1        (rs1),
    .rs2        (rs2),
    .tag        (tag),
    .mul_valid  (mul_valid),
    .mul_result (mul_result),
    .mul_tag    (mul_tag)
  );

  rv_m_div u_div (
    .clk        (clk),
    .arst_n     (arst_n),
    .div_start  (div_start),
    .op         (op),
    .rs1        (rs1),
    .rs2        (rs2),
    .tag        (tag),
    .div_ack    (div_ack),
    .div_busy   (div_busy),
    .div_done   (div_done),
    .div_result (div_result),
    .div_tag    (div_tag)
  );

  rv_m_writeback_arb u_arb (
    .clk          (clk),
    .arst_n       (arst_n),
    .mul_valid    (mul_valid),
    .mul_result   (mul_result),
    .mul_tag      (mul_tag),
    .div_done     (div_done),
    .div_result   (div_result),
    .div_tag      (div_tag),
    .div_ack      (div_ack),
    .result_valid (result_valid),
    .result       (result),
    .result_tag   (result_tag)
  );

endmodule

`default_nettype wire

// ==== src/rv_m_writeback_arb.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_m_writeback_arb (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 mul_valid,
  input  rv_m_unit_pkg::word_t mul_result,
  input  rv_m_unit_pkg::tag_t  mul_tag,
  input  logic                 div_done,
  input  rv_m_unit_pkg::word_t div_result,
  input  rv_m_unit_pkg::tag_t  div_tag,
  output logic                 div_ack,
  output logic                 result_valid,
  output rv_m_unit_pkg::word_t result,
  output rv_m_unit_pkg::tag_t  result_tag
);

  // Multiplier has no buffering, so it always wins the port
  assign div_ack = div_done && !mul_valid;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= mul_valid || div_ack;
    end
  end

  // Result and tag only change when a completion is taken
  always_ff @(posedge clk) begin
    if (mul_valid) begin
      result     <= mul_result;
      result_tag <= mul_tag;
    end else if (div_ack) begin
      result     <= div_result;
      result_tag <= div_tag;
    end
  end

endmodule

`default_nettype wire

// ==== src/rv_m_div.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_m_config.svh"

module rv_m_div (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 div_start,
  input  rv_m_isa_pkg::m_op_t  op,
  input  rv_m_unit_pkg::word_t rs1,
  input  rv_m_unit_pkg::word_t rs2,
  input  rv_m_unit_pkg::tag_t  tag,
  input  logic                 div_ack,
  output logic                 div_busy,
  output logic                 div_done,
  output rv_m_unit_pkg::word_t div_result,
  output rv_m_unit_pkg::tag_t  div_tag
);

  localparam int XLEN  = `RV_M_XLEN;
  localparam int CNT_W = `RV_M_CNT_W;
  localparam logic [CNT_W-1:0] LAST_STEP = CNT_W'(XLEN);

  rv_m_unit_pkg::div_state_t state;
  logic [CNT_W-1:0]          step_cnt;

  // Operand decode at start
  logic                 is_signed;
  logic                 rs1_neg;
  logic                 rs2_neg;
  rv_m_unit_pkg::word_t rs1_mag;
  rv_m_unit_pkg::word_t rs2_mag;

  // Captured operation
  rv_m_isa_pkg::m_op_t  op_q;
  rv_m_unit_pkg::word_t dvnd_q;
  rv_m_unit_pkg::word_t dvsr_q;
  rv_m_unit_pkg::word_t quo_q;
  rv_m_unit_pkg::word_t rem_q;
  logic                 q_neg_q;
  logic                 r_neg_q;
  logic                 zero_q;
  logic                 ovf_q;

  // One restoring step
  logic [XLEN:0]        rem_shift;
  logic                 fits;
  rv_m_unit_pkg::word_t rem_sub;

  // Fixup
  rv_m_unit_pkg::word_t quo_fix;
  rv_m_unit_pkg::word_t rem_fix;
  logic                 rem_op;

  assign is_signed = (op == rv_m_isa_pkg::OP_DIV) || (op == rv_m_isa_pkg::OP_REM);
  assign rs1_neg   = is_signed && rs1[XLEN-1];
  assign rs2_neg   = is_signed && rs2[XLEN-1];
  assign rs1_mag   = rs1_neg ? -rs1 : rs1;
  assign rs2_mag   = rs2_neg ? -rs2 : rs2;

  assign rem_shift = {rem_q, quo_q[XLEN-1]};
  assign fits      = rem_shift >= {1'b0, dvsr_q};
  // Difference is below the divisor, so it fits in a word
  assign rem_sub   = rem_shift[XLEN-1:0] - dvsr_q;

  assign rem_op = (op_q == rv_m_isa_pkg::OP_REM) || (op_q == rv_m_isa_pkg::OP_REMU);

  always_comb begin
    quo_fix = q_neg_q ? -quo_q : quo_q;
    rem_fix = r_neg_q ? -rem_q : rem_q;
    if (zero_q) begin
      quo_fix = '1;
      rem_fix = dvnd_q;
    end else if (ovf_q) begin
      quo_fix = dvnd_q;
      rem_fix = '0;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= rv_m_unit_pkg::DIV_IDLE;
      step_cnt <= '0;
    end else begin
      case (state)
        rv_m_unit_pkg::DIV_IDLE: begin
          if (div_start) begin
            state    <= rv_m_unit_pkg::DIV_RUN;
            step_cnt <= '0;
          end
        end
        rv_m_unit_pkg::DIV_RUN: begin
          // XLEN steps, then one cycle for the fixup
          if (step_cnt == LAST_STEP) begin
            state <= rv_m_unit_pkg::DIV_HOLD;
          end else begin
            step_cnt <= step_cnt + 1'b1;
          end
        end
        rv_m_unit_pkg::DIV_HOLD: begin
          if (div_ack) begin
            state <= rv_m_unit_pkg::DIV_IDLE;
          end
        end
        default: begin
          state <= rv_m_unit_pkg::DIV_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == rv_m_unit_pkg::DIV_IDLE && div_start) begin
      op_q    <= op;
      div_tag <= tag;
      dvnd_q  <= rs1;
      dvsr_q  <= rs2_mag;
      quo_q   <= rs1_mag;
      rem_q   <= '0;
      q_neg_q <= rs1_neg ^ rs2_neg;
      r_neg_q <= rs1_neg;
      zero_q  <= (rs2 == '0);
      ovf_q   <= is_signed && (rs1 == {1'b1, {(XLEN-1){1'b0}}}) && (rs2 == '1);
    end else if (state == rv_m_unit_pkg::DIV_RUN) begin
      if (step_cnt == LAST_STEP) begin
        div_result <= rem_op ? rem_fix : quo_fix;
      end else begin
        quo_q <= {quo_q[XLEN-2:0], fits};
        rem_q <= fits ? rem_sub : rem_shift[XLEN-1:0];
      end
    end
  end

  assign div_busy = (state != rv_m_unit_pkg::DIV_IDLE);
  assign div_done = (state == rv_m_unit_pkg::DIV_HOLD);

endmodule

`default_nettype wire

// ==== src/rv_m_mul.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_m_config.svh"

module rv_m_mul (
  input  logic                 clk,
  input  logic                 arst_n,
  input  logic                 mul_start,
  input  rv_m_isa_pkg::m_op_t  op,
  input  rv_m_unit_pkg::word_t rs1,
  input  rv_m_unit_pkg::word_t rs2,
  input  rv_m_unit_pkg::tag_t  tag,
  output logic                 mul_valid,
  output rv_m_unit_pkg::word_t mul_result,
  output rv_m_unit_pkg::tag_t  mul_tag
);

  localparam int XLEN = `RV_M_XLEN;
  localparam int HALF = XLEN / 2;

  // Stage 1 registers
  logic                  s1_valid;
  rv_m_isa_pkg::m_op_t   s1_op;
  rv_m_unit_pkg::tag_t   s1_tag;
  rv_m_unit_pkg::word_t  s1_a;
  rv_m_unit_pkg::word_t  s1_b;
  logic                  s1_a_neg;
  logic                  s1_b_neg;
  rv_m_unit_pkg::word_t  s1_pp_ll;
  rv_m_unit_pkg::word_t  s1_pp_lh;
  rv_m_unit_pkg::word_t  s1_pp_hl;
  rv_m_unit_pkg::word_t  s1_pp_hh;

  // Stage 2 combine
  rv_m_unit_pkg::dword_t prod_u;
  rv_m_unit_pkg::word_t  prod_hi;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid  <= 1'b0;
      mul_valid <= 1'b0;
    end else begin
      s1_valid  <= mul_start;
      mul_valid <= s1_valid;
    end
  end

  // Unsigned half-word products, signs handled in stage 2
  always_ff @(posedge clk) begin
    if (mul_start) begin
      s1_op    <= op;
      s1_tag   <= tag;
      s1_a     <= rs1;
      s1_b     <= rs2;
      s1_a_neg <= rs1[XLEN-1] &&
                  ((op == rv_m_isa_pkg::OP_MULH) || (op == rv_m_isa_pkg::OP_MULHSU));
      s1_b_neg <= rs2[XLEN-1] && (op == rv_m_isa_pkg::OP_MULH);
      s1_pp_ll <= rs1[HALF-1:0] * rs2[HALF-1:0];
      s1_pp_lh <= rs1[HALF-1:0] * rs2[XLEN-1:HALF];
      s1_pp_hl <= rs1[XLEN-1:HALF] * rs2[HALF-1:0];
      s1_pp_hh <= rs1[XLEN-1:HALF] * rs2[XLEN-1:HALF];
    end
  end

  assign prod_u = {s1_pp_hh, s1_pp_ll}
                + (rv_m_unit_pkg::dword_t'(s1_pp_lh) << HALF)
                + (rv_m_unit_pkg::dword_t'(s1_pp_hl) << HALF);

  // A negative operand contributes -2^XLEN times the other operand
  assign prod_hi = prod_u[2*XLEN-1:XLEN]
                 - (s1_a_neg ? s1_b : '0)
                 - (s1_b_neg ? s1_a : '0);

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      mul_tag <= s1_tag;
      if (s1_op == rv_m_isa_pkg::OP_MUL) begin
        mul_result <= prod_u[XLEN-1:0];
      end else begin
        mul_result <= prod_hi;
      end
    end
  end

endmodule

`default_nettype wire

// ==== src/rv_m_unit_pkg.sv ====
`default_nettype none

`include "rv_m_config.svh"

package rv_m_unit_pkg;

  // Register-sized operand or result
  typedef logic [`RV_M_XLEN-1:0] word_t;

  // Full product width
  typedef logic [2*`RV_M_XLEN-1:0] dword_t;

  // Identifies a result when it returns out of order
  typedef logic [`RV_M_TAG_W-1:0] tag_t;

  typedef enum logic [1:0] {
    DIV_IDLE,
    DIV_RUN,
    DIV_HOLD
  } div_state_t;

endpackage

`default_nettype wire

// ==== src/rv_m_isa_pkg.sv ====
`default_nettype none

`include "rv_m_config.svh"

package rv_m_isa_pkg;

  // funct3 field of the M extension
  typedef logic [2:0] m_op_t;

  // Multiply class, bit 2 clear
  localparam m_op_t OP_MUL    = 3'b000;
  localparam m_op_t OP_MULH   = 3'b001;
  localparam m_op_t OP_MULHSU = 3'b010;
  localparam m_op_t OP_MULHU  = 3'b011;

  // Division class, bit 2 set
  localparam m_op_t OP_DIV    = 3'b100;
  localparam m_op_t OP_DIVU   = 3'b101;
  localparam m_op_t OP_REM    = 3'b110;
  localparam m_op_t OP_REMU   = 3'b111;

endpackage

`default_nettype wire

// ==== include/rv_m_config.svh ====
`ifndef RV_M_CONFIG_SVH
`define RV_M_CONFIG_SVH

// Data width of rs1, rs2 and the result
`define RV_M_XLEN 32

// Width of the result tag returned with each completion
`define RV_M_TAG_W 4

// Divider step counter, must hold the value XLEN
`define RV_M_CNT_W 6

`endif
